// File: verilog/glay_cfg.svh
`ifndef GLAY_CFG_SVH
`define GLAY_CFG_SVH

// ------------------------------------------------------------
// Engine FIFO sizing
// ------------------------------------------------------------
// Entries per engine FIFO
`define GLAY_FIFO_DEPTH 16
// Ready drops at this occupancy
// Slack above it covers the in-flight input registers
`define GLAY_PROG_THRESH 12

// ------------------------------------------------------------
// Packet field widths
// ------------------------------------------------------------
`define GLAY_VERTEX_W 16
`define GLAY_VALUE_W 16

// Control opcode marking end of stream
`define GLAY_OP_END 8'hFF

`endif

// File: verilog/glay_pkg.sv
`default_nettype none

`include "glay_cfg.svh"

package glay_pkg;

    // ------------------------------------------------------------
    // Packet kind and the two views of one packet word
    // ------------------------------------------------------------
    typedef enum logic {
        PKT_DATA = 1'b0,
        PKT_CTRL = 1'b1
    } packet_kind_t;

    // Data view, vertex id in the upper half
    typedef struct packed {
        logic [`GLAY_VERTEX_W-1:0] vertex_id;
        logic [`GLAY_VALUE_W-1:0]  value;
    } data_view_t;

    // Control view, opcode in the top byte
    typedef struct packed {
        logic [7:0]  opcode;
        logic [23:0] reserved;
    } ctrl_view_t;

    // Same 32 bits, decoded by kind
    typedef union packed {
        data_view_t data;
        ctrl_view_t ctrl;
    } packet_word_u;

    // Engine packet as carried on streams and the lane
    typedef struct packed {
        packet_kind_t kind;
        packet_word_u word;
    } engine_packet_t;

    // Kernel descriptor, only the rebase offset is used here
    typedef struct packed {
        logic                      valid;
        logic [`GLAY_VERTEX_W-1:0] base_vertex;
    } descriptor_t;

endpackage

`default_nettype wire

// File: verilog/engine_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// Forwarded stream of one engine toward the lane arbiter
interface engine_stream_if;
    import glay_pkg::*;

    // Held by the engine until a cycle with valid and grant both high
    logic           valid;
    engine_packet_t packet;
    // From the arbiter, only given while valid is high
    logic           grant;
    // Sticky end-of-stream status
    logic           done;

    modport engine (
        output valid,
        output packet,
        output done,
        input  grant
    );

    modport arbiter (
        input  valid,
        input  packet,
        input  done,
        output grant
    );

endinterface

`default_nettype wire

// File: verilog/forward_data_generator.sv
`timescale 1ns/1ps
`default_nettype none

`include "glay_cfg.svh"

module forward_data_generator (
    input  logic                     ap_clk,
    input  logic                     areset,
    input  glay_pkg::descriptor_t    descriptor,
    input  logic                     in_valid,
    input  glay_pkg::engine_packet_t in_packet,
    output logic                     in_ready,
    output logic                     fifo_setup,
    engine_stream_if.engine          stream
);
    import glay_pkg::*;

    localparam int ADDR_W = $clog2(`GLAY_FIFO_DEPTH);
    localparam int CNT_W  = ADDR_W + 1;

    // ------------------------------------------------------------
    // State
    // ------------------------------------------------------------
    engine_packet_t            fifo_mem [`GLAY_FIFO_DEPTH];
    logic [ADDR_W-1:0]         wr_ptr;
    logic [ADDR_W-1:0]         rd_ptr;
    logic [CNT_W-1:0]          count;
    logic                      setup_q;
    logic                      desc_latched;
    logic [`GLAY_VERTEX_W-1:0] base_q;
    logic                      end_seen;
    logic                      wr_en;
    logic                      rd_en;
    logic                      out_free;
    logic                      is_end;
    engine_packet_t            head;
    engine_packet_t            rebased;

    // Output slot is free when empty or leaving this cycle
    assign out_free   = !stream.valid || stream.grant;
    // Overflow guard, flow control should keep this from firing
    assign wr_en      = in_valid && (count != CNT_W'(`GLAY_FIFO_DEPTH));
    // Nothing drains before a descriptor arrives
    assign rd_en      = desc_latched && (count != '0) && out_free;
    assign in_ready   = !setup_q && (count < CNT_W'(`GLAY_PROG_THRESH));
    assign fifo_setup = setup_q;
    assign head       = fifo_mem[rd_ptr];
    assign is_end     = (head.kind == PKT_CTRL) && (head.word.ctrl.opcode == `GLAY_OP_END);

    // Data packets get the base added, control passes untouched
    always_comb begin
        rebased = head;
        if (head.kind == PKT_DATA) begin
            rebased.word.data.vertex_id = head.word.data.vertex_id + base_q;
        end
    end

    // ------------------------------------------------------------
    // Circular FIFO
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            fifo_mem[wr_ptr] <= in_packet;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own, depth is a power of two
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Setup and descriptor gate
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            setup_q      <= 1'b1;
            desc_latched <= 1'b0;
        end else begin
            setup_q <= 1'b0;
            if (descriptor.valid) desc_latched <= 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (descriptor.valid) base_q <= descriptor.base_vertex;
    end

    // ------------------------------------------------------------
    // Output register, END detection and done
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            stream.valid <= 1'b0;
            stream.done  <= 1'b0;
            end_seen     <= 1'b0;
        end else begin
            if (rd_en) begin
                // END is consumed here and never forwarded
                if (is_end) begin
                    end_seen     <= 1'b1;
                    stream.valid <= 1'b0;
                end else begin
                    stream.valid <= 1'b1;
                end
            end else if (stream.grant) begin
                stream.valid <= 1'b0;
            end
            // Done only once drained and the last packet has left
            if (end_seen && (count == '0) && !stream.valid) stream.done <= 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (rd_en) stream.packet <= rebased;
    end

endmodule

`default_nettype wire

// File: verilog/engine_forward_data.sv
`timescale 1ns/1ps
`default_nettype none

module engine_forward_data (
    input  logic                     ap_clk,
    input  logic                     areset_forward_data_engine,
    input  glay_pkg::descriptor_t    descriptor_in,
    input  logic                     in_valid,
    input  glay_pkg::engine_packet_t in_packet,
    output logic                     in_ready,
    output logic                     fifo_setup,
    engine_stream_if.engine          stream
);
    import glay_pkg::*;

    // ------------------------------------------------------------
    // Local signals
    // ------------------------------------------------------------
    logic           areset_engine;
    logic           areset_generator;
    descriptor_t    descriptor_reg;
    logic           in_valid_reg;
    engine_packet_t in_packet_reg;
    logic           gen_in_ready;
    logic           gen_fifo_setup;

    // Separate reset copies for the wrapper and the generator
    always_ff @(posedge ap_clk) begin
        areset_engine    <= areset_forward_data_engine;
        areset_generator <= areset_forward_data_engine;
    end

    // ------------------------------------------------------------
    // Descriptor register
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            descriptor_reg.valid <= 1'b0;
        end else begin
            descriptor_reg.valid <= descriptor_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        descriptor_reg.base_vertex <= descriptor_in.base_vertex;
    end

    // ------------------------------------------------------------
    // Input stream register
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            in_valid_reg <= 1'b0;
        end else begin
            in_valid_reg <= in_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        in_packet_reg <= in_packet;
    end

    // Status outputs, setup held high through reset
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            in_ready   <= 1'b0;
            fifo_setup <= 1'b1;
        end else begin
            in_ready   <= gen_in_ready;
            fifo_setup <= gen_fifo_setup;
        end
    end

    forward_data_generator inst_forward_data_generator (
        .ap_clk     (ap_clk),
        .areset     (areset_generator),
        .descriptor (descriptor_reg),
        .in_valid   (in_valid_reg),
        .in_packet  (in_packet_reg),
        .in_ready   (gen_in_ready),
        .fifo_setup (gen_fifo_setup),
        .stream     (stream)
    );

endmodule

`default_nettype wire

// File: verilog/lane_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module lane_arbiter (
    input  logic                     ap_clk,
    input  logic                     areset,
    engine_stream_if.arbiter         eng0,
    engine_stream_if.arbiter         eng1,
    input  logic                     out_ready,
    output logic                     out_valid,
    output glay_pkg::engine_packet_t out_packet,
    output logic                     out_engine,
    output logic                     done
);
    import glay_pkg::*;

    logic           last_engine;
    logic           gnt0;
    logic           gnt1;
    logic           sel_engine;
    engine_packet_t sel_packet;

    // ------------------------------------------------------------
    // Round-robin grant, nothing while the sink stalls
    // ------------------------------------------------------------
    always_comb begin
        gnt0 = 1'b0;
        gnt1 = 1'b0;
        if (out_ready) begin
            if (eng0.valid && eng1.valid) begin
                // Both asking, serve the one not served last
                gnt0 = last_engine;
                gnt1 = !last_engine;
            end else begin
                gnt0 = eng0.valid;
                gnt1 = eng1.valid;
            end
        end
    end

    assign eng0.grant = gnt0;
    assign eng1.grant = gnt1;
    assign sel_engine = gnt1;
    assign sel_packet = gnt1 ? eng1.packet : eng0.packet;

    // ------------------------------------------------------------
    // Shared lane register, held while out_ready is low
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            out_valid   <= 1'b0;
            last_engine <= 1'b0;
            done        <= 1'b0;
        end else begin
            if (out_ready) begin
                out_valid <= gnt0 || gnt1;
                if (gnt0 || gnt1) last_engine <= sel_engine;
            end
            // Sticky, and only once the lane itself is empty
            if (eng0.done && eng1.done && !out_valid) done <= 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (gnt0 || gnt1) begin
            out_packet <= sel_packet;
            out_engine <= sel_engine;
        end
    end

endmodule

`default_nettype wire

// File: verilog/forward_lane_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "glay_cfg.svh"

module forward_lane_top (
    input  logic                      ap_clk,
    input  logic                      areset_forward_data_engine,
    input  logic                      descriptor_valid,
    input  logic [`GLAY_VERTEX_W-1:0] descriptor_base,
    input  logic                      in_valid_0,
    input  glay_pkg::engine_packet_t  in_packet_0,
    output logic                      in_ready_0,
    input  logic                      in_valid_1,
    input  glay_pkg::engine_packet_t  in_packet_1,
    output logic                      in_ready_1,
    input  logic                      out_ready,
    output logic                      out_valid,
    output glay_pkg::engine_packet_t  out_packet,
    output logic                      out_engine,
    output logic                      fifo_setup_0,
    output logic                      fifo_setup_1,
    output logic                      done
);
    import glay_pkg::*;

    // One descriptor shared by both peers
    descriptor_t descriptor;

    assign descriptor.valid       = descriptor_valid;
    assign descriptor.base_vertex = descriptor_base;

    engine_stream_if stream_0 ();
    engine_stream_if stream_1 ();

    // ------------------------------------------------------------
    // Engine peers
    // ------------------------------------------------------------
    engine_forward_data inst_engine_0 (
        .ap_clk                     (ap_clk),
        .areset_forward_data_engine (areset_forward_data_engine),
        .descriptor_in              (descriptor),
        .in_valid                   (in_valid_0),
        .in_packet                  (in_packet_0),
        .in_ready                   (in_ready_0),
        .fifo_setup                 (fifo_setup_0),
        .stream                     (stream_0)
    );

    engine_forward_data inst_engine_1 (
        .ap_clk                     (ap_clk),
        .areset_forward_data_engine (areset_forward_data_engine),
        .descriptor_in              (descriptor),
        .in_valid                   (in_valid_1),
        .in_packet                  (in_packet_1),
        .in_ready                   (in_ready_1),
        .fifo_setup                 (fifo_setup_1),
        .stream                     (stream_1)
    );

    // Shared output lane
    lane_arbiter inst_lane_arbiter (
        .ap_clk     (ap_clk),
        .areset     (areset_forward_data_engine),
        .eng0       (stream_0),
        .eng1       (stream_1),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_packet (out_packet),
        .out_engine (out_engine),
        .done       (done)
    );

endmodule

`default_nettype wire

// File: sim/lane_sva.sv
`timescale 1ns/1ps
`default_nettype none

module lane_sva (
    input logic                     ap_clk,
    input logic                     areset,
    input logic                     out_ready,
    input logic                     out_valid,
    input glay_pkg::engine_packet_t out_packet,
    input logic                     out_engine,
    input logic                     done,
    input logic                     gnt0,
    input logic                     gnt1,
    input logic                     eng0_valid,
    input logic                     eng1_valid,
    input glay_pkg::engine_packet_t eng0_packet,
    input glay_pkg::engine_packet_t eng1_packet
);

    // ------------------------------------------------------------
    // Lane register holds while the sink stalls
    // ------------------------------------------------------------
    property p_hold_on_stall;
        @(posedge ap_clk) disable iff (areset)
            !out_ready |=> $stable(out_valid)
                && (!out_valid || ($stable(out_packet) && $stable(out_engine)));
    endproperty

    // A requesting engine keeps valid and packet until it is granted
    property p_hold_until_grant_0;
        @(posedge ap_clk) disable iff (areset)
            eng0_valid && !gnt0 |=> eng0_valid && $stable(eng0_packet);
    endproperty

    property p_hold_until_grant_1;
        @(posedge ap_clk) disable iff (areset)
            eng1_valid && !gnt1 |=> eng1_valid && $stable(eng1_packet);
    endproperty

    // Done is sticky and the lane stays idle behind it
    property p_done_idle;
        @(posedge ap_clk) disable iff (areset)
            done |=> done && !out_valid && !eng0_valid && !eng1_valid;
    endproperty

    a_hold_on_stall: assert property (p_hold_on_stall)
        else $error("lane register changed while out_ready was low");
    a_hold_until_grant_0: assert property (p_hold_until_grant_0)
        else $error("engine 0 dropped or changed its packet before the grant");
    a_hold_until_grant_1: assert property (p_hold_until_grant_1)
        else $error("engine 1 dropped or changed its packet before the grant");
    a_done_idle: assert property (p_done_idle)
        else $error("done fell or the lane was busy after done");

endmodule

`default_nettype wire

// File: sim/lane_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "glay_cfg.svh"

module lane_tb;
    import glay_pkg::*;

    localparam int WAIT_LIMIT = 2000;

    logic                      ap_clk;
    logic                      areset_forward_data_engine;
    logic                      descriptor_valid;
    logic [`GLAY_VERTEX_W-1:0] descriptor_base;
    logic                      in_valid_0;
    engine_packet_t            in_packet_0;
    logic                      in_ready_0;
    logic                      in_valid_1;
    engine_packet_t            in_packet_1;
    logic                      in_ready_1;
    logic                      out_ready;
    logic                      out_valid;
    engine_packet_t            out_packet;
    logic                      out_engine;
    logic                      fifo_setup_0;
    logic                      fifo_setup_1;
    logic                      done;

    // Expected packets per engine as built from the trace
    engine_packet_t exp_q0[$];
    engine_packet_t exp_q1[$];
    // Trace rows
    int             tr_eng[$];
    int             tr_kind[$];
    logic [15:0]    tr_a[$];
    logic [15:0]    tr_b[$];
    logic [15:0]    base;
    // 0 random stalls, 1 held low, 2 held high
    int             sink_mode;
    logic           monitor_on;
    logic           done_seen;

    forward_lane_top UUT (
        .ap_clk                     (ap_clk),
        .areset_forward_data_engine (areset_forward_data_engine),
        .descriptor_valid           (descriptor_valid),
        .descriptor_base            (descriptor_base),
        .in_valid_0                 (in_valid_0),
        .in_packet_0                (in_packet_0),
        .in_ready_0                 (in_ready_0),
        .in_valid_1                 (in_valid_1),
        .in_packet_1                (in_packet_1),
        .in_ready_1                 (in_ready_1),
        .out_ready                  (out_ready),
        .out_valid                  (out_valid),
        .out_packet                 (out_packet),
        .out_engine                 (out_engine),
        .fifo_setup_0               (fifo_setup_0),
        .fifo_setup_1               (fifo_setup_1),
        .done                       (done)
    );

    bind lane_arbiter lane_sva inst_lane_sva (
        .ap_clk      (ap_clk),
        .areset      (areset),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_packet  (out_packet),
        .out_engine  (out_engine),
        .done        (done),
        .gnt0        (gnt0),
        .gnt1        (gnt1),
        .eng0_valid  (eng0.valid),
        .eng1_valid  (eng1.valid),
        .eng0_packet (eng0.packet),
        .eng1_packet (eng1.packet)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    // Packet as the trace describes it before rebasing
    function automatic engine_packet_t make_packet(input int kind, input logic [15:0] a,
                                                   input logic [15:0] b);
        engine_packet_t p;
        p = '0;
        if (kind == 0) begin
            p.kind = PKT_DATA;
            p.word.data.vertex_id = a;
            p.word.data.value = b;
        end else begin
            p.kind = PKT_CTRL;
            p.word.ctrl.opcode = a[7:0];
        end
        return p;
    endfunction

    task automatic read_trace();
        int    fd;
        int    e;
        int    k;
        int    n;
        logic [15:0] a;
        logic [15:0] b;
        string line;
        logic  have_base;
        fd = $fopen("sim/lane_trace.txt", "r");
        have_base = 1'b0;
        assert (fd != 0) else fail_run("Could not open the trace file");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Skip comments and blank lines
            if (line.len() == 0 || line[0] == 8'h23) continue;
            if (!have_base) begin
                n = $sscanf(line, "%h", base);
                if (n == 1) have_base = 1'b1;
            end else begin
                n = $sscanf(line, "%h %h %h %h", e, k, a, b);
                if (n == 4) begin
                    tr_eng.push_back(e);
                    tr_kind.push_back(k);
                    tr_a.push_back(a);
                    tr_b.push_back(b);
                end
            end
        end
        $fclose(fd);
        assert (have_base && tr_eng.size() > 0) else fail_run("The trace file holds no packets");
    endtask

    // Rebased copy goes to the engine's queue and END is dropped
    task automatic expect_packet(input int eng, input int kind, input logic [15:0] a,
                                 input logic [15:0] b);
        if (kind == 0) begin
            if (eng == 0) exp_q0.push_back(make_packet(0, 16'(a + base), b));
            else          exp_q1.push_back(make_packet(0, 16'(a + base), b));
        end
    endtask

    task automatic send_packet(input int eng, input engine_packet_t pkt);
        int waited;
        waited = 0;
        @(posedge ap_clk);
        while (!(eng == 0 ? in_ready_0 : in_ready_1)) begin
            waited++;
            assert (waited < WAIT_LIMIT) else fail_run("Timed out waiting for in_ready");
            @(posedge ap_clk);
        end
        if (eng == 0) begin
            in_valid_0  <= 1'b1;
            in_packet_0 <= pkt;
        end else begin
            in_valid_1  <= 1'b1;
            in_packet_1 <= pkt;
        end
        @(posedge ap_clk);
        in_valid_0 <= 1'b0;
        in_valid_1 <= 1'b0;
    endtask

    // ------------------------------------------------------------
    // Sink back-pressure
    // ------------------------------------------------------------
    always @(posedge ap_clk) begin
        case (sink_mode)
            0:       out_ready <= ($urandom % 4) != 0;
            1:       out_ready <= 1'b0;
            default: out_ready <= 1'b1;
        endcase
    end

    // Output checks away from the rising edge
    always @(negedge ap_clk) begin
        engine_packet_t exp;
        if (monitor_on) begin
            if (done_seen) begin
                assert (done) else fail_run("done fell after it had risen");
            end
            if (done) begin
                done_seen = 1'b1;
                assert (exp_q0.size() == 0 && exp_q1.size() == 0)
                    else fail_run("done rose while packets were still expected");
            end
            if (out_valid && out_ready) begin
                assert (out_packet.kind == PKT_DATA)
                    else fail_run($sformatf("[FAIL] out_packet.kind got %h expected %h",
                                            out_packet.kind, PKT_DATA));
                if (out_engine) begin
                    assert (exp_q1.size() > 0) else fail_run("Unexpected packet from engine 1");
                    exp = exp_q1.pop_front();
                end else begin
                    assert (exp_q0.size() > 0) else fail_run("Unexpected packet from engine 0");
                    exp = exp_q0.pop_front();
                end
                assert (out_packet == exp)
                    else fail_run($sformatf("[FAIL] out_packet got %h expected %h",
                                            out_packet, exp));
            end
        end
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int accepted;
        int waited;
        engine_packet_t pkt;
        areset_forward_data_engine = 1'b1;
        descriptor_valid = 1'b0;
        descriptor_base  = '0;
        in_valid_0  = 1'b0;
        in_packet_0 = '0;
        in_valid_1  = 1'b0;
        in_packet_1 = '0;
        out_ready   = 1'b1;
        sink_mode   = 2;
        monitor_on  = 1'b0;
        done_seen   = 1'b0;
        void'($urandom(32'h1dc2));
        base = '0;
        read_trace();

        // Reset for 16 cycles with the outputs idle throughout
        for (int i = 0; i < 16; i++) begin
            @(posedge ap_clk);
            if (i == 15) areset_forward_data_engine <= 1'b0;
            @(negedge ap_clk);
            if (i >= 3) begin
                assert (!out_valid && !done)
                    else fail_run($sformatf("[FAIL] out_valid/done got %h/%h expected 0/0",
                                            out_valid, done));
                assert (fifo_setup_0 && fifo_setup_1)
                    else fail_run($sformatf("[FAIL] fifo_setup_0/1 got %h/%h expected 1/1",
                                            fifo_setup_0, fifo_setup_1));
            end
        end
        monitor_on <= 1'b1;

        waited = 0;
        while (fifo_setup_0 || fifo_setup_1) begin
            waited++;
            assert (waited < WAIT_LIMIT) else fail_run("Timed out waiting for fifo_setup to fall");
            @(posedge ap_clk);
        end

        // One descriptor pulse for both engines
        @(posedge ap_clk);
        descriptor_valid <= 1'b1;
        descriptor_base  <= base;
        @(posedge ap_clk);
        descriptor_valid <= 1'b0;
        repeat (4) @(posedge ap_clk);

        // With the sink stalled engine 0 must drop ready within the FIFO depth
        sink_mode <= 1;
        repeat (3) @(posedge ap_clk);
        accepted = 0;
        waited = 0;
        @(posedge ap_clk);
        while (in_ready_0) begin
            pkt = make_packet(0, 16'(16'h0100 + accepted), 16'(16'h5a00 + accepted));
            in_valid_0  <= 1'b1;
            in_packet_0 <= pkt;
            expect_packet(0, 0, pkt.word.data.vertex_id, pkt.word.data.value);
            accepted++;
            waited++;
            assert (waited < WAIT_LIMIT) else fail_run("Timed out waiting for in_ready_0 to fall");
            @(posedge ap_clk);
        end
        in_valid_0 <= 1'b0;
        assert (accepted <= `GLAY_FIFO_DEPTH)
            else fail_run($sformatf("[FAIL] accepted strobes got %h expected at most %h",
                                    accepted, `GLAY_FIFO_DEPTH));

        // Ready comes back once the sink resumes
        sink_mode <= 0;
        waited = 0;
        @(posedge ap_clk);
        while (!in_ready_0) begin
            waited++;
            assert (waited < WAIT_LIMIT) else fail_run("Timed out waiting for in_ready_0 to rise");
            @(posedge ap_clk);
        end

        // Trace packets with random gaps and random stalls
        for (int i = 0; i < tr_eng.size(); i++) begin
            repeat ($urandom % 3) @(posedge ap_clk);
            expect_packet(tr_eng[i], tr_kind[i], tr_a[i], tr_b[i]);
            send_packet(tr_eng[i], make_packet(tr_kind[i], tr_a[i], tr_b[i]));
        end

        // Drain and wait for done
        sink_mode <= 2;
        waited = 0;
        @(posedge ap_clk);
        while (!done) begin
            waited++;
            assert (waited < WAIT_LIMIT) else fail_run("Timed out waiting for done");
            @(posedge ap_clk);
        end
        // The monitor keeps watching done while it holds
        repeat (20) @(posedge ap_clk);
        @(negedge ap_clk);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/glay_pkg.sv
verilog/engine_stream_if.sv
verilog/forward_data_generator.sv
verilog/engine_forward_data.sv
verilog/lane_arbiter.sv
verilog/forward_lane_top.sv
sim/lane_sva.sv
sim/lane_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the forwarding lane testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module lane_tb \
    -Mdir obj_dir -o lane_sim \
    && ./obj_dir/lane_sim | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: sim/lane_trace.txt
# First data line: descriptor base vertex (hex)
# Then: engine kind(0 data, 1 ctrl) vertex_or_opcode value (all hex)
0400
0 0 0001 1111
1 0 0002 2222
0 0 0003 3333
0 0 0010 aaaa
1 0 0020 bbbb
1 0 fff0 cccc
0 0 0042 0042
1 0 0100 dead
0 0 00ff beef
1 0 0007 7777
0 0 0055 5555
1 0 0abc 0def
0 1 00ff 0000
1 1 00ff 0000
